// File: design/rvx_pkg.sv
`default_nettype none

package rvx_pkg;

	localparam int XLEN = 32;

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	typedef enum logic [2:0] {
		FMT_R = 3'd0,
		FMT_I = 3'd1,
		FMT_S = 3'd2,
		FMT_B = 3'd3,
		FMT_U = 3'd4,
		FMT_J = 3'd5
	} inst_fmt_e;

	typedef enum logic [3:0] {
		OP_ADD   = 4'd0,
		OP_SUB   = 4'd1,
		OP_AND   = 4'd2,
		OP_XOR   = 4'd3,
		OP_OR    = 4'd4,
		OP_SRL   = 4'd5,
		OP_SRA   = 4'd6,
		OP_SLL   = 4'd7,
		OP_LESS  = 4'd8,
		OP_ULESS = 4'd9
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_r_t;

	// same bits, with imm[11:5] on top and imm[4:0] where rd sits
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} inst_imm_t;

	typedef union packed {
		inst_r_t   r;
		inst_imm_t i;
	} rv_inst_u;

endpackage

`default_nettype wire

// File: design/rvx_idu.sv
`timescale 1ns/1ps
`default_nettype none

module rvx_idu import rvx_pkg::*; (
	input  logic            inst_valid,
	input  logic [31:0]     inst,
	output inst_fmt_e       fmt,
	output logic [6:0]      opcode,
	output logic [2:0]      funct3,
	output logic [6:0]      funct7,
	output logic [4:0]      rd,
	output logic [4:0]      rs1,
	output logic [4:0]      rs2,
	output logic [XLEN-1:0] imm
);

	rv_inst_u iw;
	logic     has_rs1;
	logic     has_rs2;

	assign iw = inst;

	assign opcode = iw.r.opcode;
	assign funct3 = iw.r.funct3;
	assign funct7 = iw.r.funct7;
	assign rd     = iw.r.rd;

	always_comb begin
		case (iw.r.opcode)
			OPC_LUI, OPC_AUIPC: fmt = FMT_U;
			OPC_JAL:            fmt = FMT_J;
			OPC_BRANCH:         fmt = FMT_B;
			OPC_STORE:          fmt = FMT_S;
			OPC_OP:             fmt = FMT_R;
			default:            fmt = FMT_I; // jalr, op-imm, system
		endcase
	end

	assign has_rs1 = (fmt == FMT_R) || (fmt == FMT_I) || (fmt == FMT_S) || (fmt == FMT_B);
	assign has_rs2 = (fmt == FMT_R) || (fmt == FMT_S) || (fmt == FMT_B);

	// unused sources read as x0 so no phantom forward
	assign rs1 = (inst_valid && has_rs1) ? iw.r.rs1 : 5'd0;
	assign rs2 = (inst_valid && has_rs2) ? iw.r.rs2 : 5'd0;

	always_comb begin
		case (fmt)
			FMT_I: imm = {{20{iw.i.imm_hi[6]}}, iw.i.imm_hi, iw.i.rs2};
			FMT_S: imm = {{20{iw.i.imm_hi[6]}}, iw.i.imm_hi, iw.i.imm_lo};
			FMT_B: imm = {{19{iw.i.imm_hi[6]}}, iw.i.imm_hi[6], iw.i.imm_lo[0],
				iw.i.imm_hi[5:0], iw.i.imm_lo[4:1], 1'b0};
			FMT_U: imm = {iw.i.imm_hi, iw.i.rs2, iw.i.rs1, iw.i.funct3, 12'b0};
			FMT_J: imm = {{11{iw.i.imm_hi[6]}}, iw.i.imm_hi[6], iw.i.rs1, iw.i.funct3,
				iw.i.rs2[0], iw.i.imm_hi[5:0], iw.i.rs2[4:1], 1'b0};
			default: imm = '0; // r-type
		endcase
	end

endmodule

`default_nettype wire

// File: design/rvx_gpr.sv
`timescale 1ns/1ps
`default_nettype none

module rvx_gpr import rvx_pkg::*; #(
	parameter int NREGS = 32
) (
	input  logic            clock,
	input  logic            arst_n,
	input  logic [4:0]      raddr1,
	input  logic [4:0]      raddr2,
	output logic [XLEN-1:0] rdata1,
	output logic [XLEN-1:0] rdata2,
	input  logic            we,
	input  logic [4:0]      waddr,
	input  logic [XLEN-1:0] wdata
);

	logic [XLEN-1:0] regs [NREGS]; // x0 cleared at reset, never written

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != 5'd0 && waddr < NREGS) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 < NREGS) ? regs[raddr1] : '0;
	assign rdata2 = (raddr2 < NREGS) ? regs[raddr2] : '0;

	a_x0_stays_zero: assert property (@(posedge clock) disable iff (!arst_n)
		(we && waddr == 5'd0) |=> ((raddr1 != 5'd0 || rdata1 == '0) &&
		(raddr2 != 5'd0 || rdata2 == '0)));

endmodule

`default_nettype wire

// File: design/rvx_id_ex_buf.sv
`timescale 1ns/1ps
`default_nettype none

module rvx_id_ex_buf import rvx_pkg::*; #(
	parameter int NREGS = 32
) (
	input  logic            clock,
	input  logic            arst_n,
	input  logic            inst_valid,
	input  inst_fmt_e       fmt,
	input  logic [6:0]      opcode,
	input  logic [2:0]      funct3,
	input  logic [6:0]      funct7,
	input  logic [4:0]      rd,
	input  logic [4:0]      rs1,
	input  logic [4:0]      rs2,
	input  logic [XLEN-1:0] imm,
	input  logic [XLEN-1:0] rdata1,
	input  logic [XLEN-1:0] rdata2,
	input  logic [XLEN-1:0] pc,
	input  logic            wb_we,
	input  logic [4:0]      wb_rd,
	input  logic [XLEN-1:0] wb_data,
	output logic            ex_valid,
	output inst_fmt_e       ex_fmt,
	output logic [6:0]      ex_opcode,
	output logic [2:0]      ex_funct3,
	output logic [6:0]      ex_funct7,
	output logic [4:0]      ex_rd,
	output logic [XLEN-1:0] ex_imm,
	output logic [XLEN-1:0] ex_pc,
	output logic [XLEN-1:0] src1,
	output logic [XLEN-1:0] src2
);

	logic wb_hit; // writeback lands in the file this cycle
	logic fwd1;
	logic fwd2;

	assign wb_hit = wb_we && wb_rd != 5'd0 && wb_rd < NREGS;
	assign fwd1   = wb_hit && (wb_rd == rs1);
	assign fwd2   = wb_hit && (wb_rd == rs2);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid  <= 1'b0;
			ex_fmt    <= FMT_R;
			ex_opcode <= '0;
			ex_funct3 <= '0;
			ex_funct7 <= '0;
			ex_rd     <= '0;
			ex_imm    <= '0;
			ex_pc     <= '0;
			src1      <= '0;
			src2      <= '0;
		end else begin
			ex_valid <= inst_valid; // single-cycle pulse per strobe
			if (inst_valid) begin
				ex_fmt    <= fmt;
				ex_opcode <= opcode;
				ex_funct3 <= funct3;
				ex_funct7 <= funct7;
				ex_rd     <= rd;
				ex_imm    <= imm;
				ex_pc     <= pc;
				src1      <= fwd1 ? wb_data : rdata1;
				src2      <= fwd2 ? wb_data : rdata2;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/rvx_exu.sv
`timescale 1ns/1ps
`default_nettype none

module rvx_exu import rvx_pkg::*; (
	input  logic            ex_valid,
	input  inst_fmt_e       fmt,
	input  logic [6:0]      opcode,
	input  logic [2:0]      funct3,
	input  logic [6:0]      funct7,
	input  logic [4:0]      rd,
	input  logic [XLEN-1:0] src1,
	input  logic [XLEN-1:0] src2,
	input  logic [XLEN-1:0] imm,
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] csr_rdata,
	output logic            wb_we,
	output logic [4:0]      wb_rd,
	output logic [XLEN-1:0] wb_data,
	output logic            jump_valid,
	output logic [XLEN-1:0] jump_target,
	output logic            store_valid,
	output logic [XLEN-1:0] store_addr,
	output logic [XLEN-1:0] store_data,
	output logic [3:0]      store_wmask,
	output logic            csr_we,
	output logic [XLEN-1:0] csr_wdata
);

	logic            is_jal, is_jalr, is_branch, is_store, is_alu, is_csr;
	logic [XLEN-1:0] lop, rop;
	alu_op_e         alu_op;
	logic [XLEN-1:0] alu_res;
	logic [XLEN-1:0] op_diff, br_diff, jump_sum;
	logic            op_borrow, op_less;
	logic            br_borrow, br_eq, br_less, br_taken;

	assign is_jal    = (fmt == FMT_J);
	assign is_jalr   = (opcode == OPC_JALR);
	assign is_branch = (fmt == FMT_B);
	assign is_store  = (opcode == OPC_STORE);
	assign is_alu    = (opcode == OPC_OPIMM) || (opcode == OPC_OP);
	assign is_csr    = (opcode == OPC_SYSTEM) && (funct3 == 3'b001 || funct3 == 3'b010);

	always_comb begin
		lop = '0;
		rop = '0;
		case (opcode)
			OPC_LUI:   rop = imm;
			OPC_AUIPC: begin
				lop = pc;
				rop = imm;
			end
			OPC_JAL, OPC_JALR: begin
				lop = pc;
				rop = 32'd4; // link value
			end
			OPC_STORE, OPC_OPIMM: begin
				lop = src1;
				rop = imm;
			end
			OPC_OP: begin
				lop = src1;
				rop = src2;
			end
			default: ;
		endcase
	end

	always_comb begin
		alu_op = OP_ADD;
		if (is_alu) begin
			case (funct3)
				3'b000:  alu_op = (opcode == OPC_OP && funct7[5]) ? OP_SUB : OP_ADD;
				3'b001:  alu_op = OP_SLL;
				3'b010:  alu_op = OP_LESS;
				3'b011:  alu_op = OP_ULESS;
				3'b100:  alu_op = OP_XOR;
				3'b101:  alu_op = funct7[5] ? OP_SRA : OP_SRL;
				3'b110:  alu_op = OP_OR;
				default: alu_op = OP_AND;
			endcase
		end
	end

	assign {op_borrow, op_diff} = {1'b0, lop} - {1'b0, rop};
	assign op_less = (lop[31] & ~rop[31]) | (~(lop[31] ^ rop[31]) & op_diff[31]);

	always_comb begin
		case (alu_op)
			OP_ADD:   alu_res = lop + rop;
			OP_SUB:   alu_res = op_diff;
			OP_AND:   alu_res = lop & rop;
			OP_XOR:   alu_res = lop ^ rop;
			OP_OR:    alu_res = lop | rop;
			OP_SRL:   alu_res = lop >> rop[4:0];
			OP_SRA:   alu_res = $signed(lop) >>> rop[4:0];
			OP_SLL:   alu_res = lop << rop[4:0];
			OP_LESS:  alu_res = {31'b0, op_less};
			OP_ULESS: alu_res = {31'b0, op_borrow};
			default:  alu_res = '0;
		endcase
	end

	// branch compare on raw sources
	assign {br_borrow, br_diff} = {1'b0, src1} - {1'b0, src2};
	assign br_eq   = (br_diff == '0);
	assign br_less = (src1[31] & ~src2[31]) | (~(src1[31] ^ src2[31]) & br_diff[31]);

	always_comb begin
		case (funct3)
			3'b000:  br_taken = br_eq;
			3'b001:  br_taken = ~br_eq;
			3'b100:  br_taken = br_less;
			3'b101:  br_taken = ~br_less;
			3'b110:  br_taken = br_borrow;
			3'b111:  br_taken = ~br_borrow;
			default: br_taken = 1'b0;
		endcase
	end

	assign jump_sum    = (is_jalr ? src1 : pc) + imm;
	assign jump_target = {jump_sum[XLEN-1:1], jump_sum[0] & ~is_jalr};
	assign jump_valid  = ex_valid && (is_jal || is_jalr || (is_branch && br_taken));

	assign store_valid = ex_valid && is_store;
	assign store_addr  = alu_res;
	assign store_data  = src2;

	always_comb begin
		case (funct3[1:0])
			2'b00:   store_wmask = 4'h1; // sb
			2'b01:   store_wmask = 4'h3; // sh
			2'b10:   store_wmask = 4'hf; // sw
			default: store_wmask = 4'h0;
		endcase
	end

	assign csr_we    = ex_valid && is_csr;
	assign csr_wdata = funct3[1] ? (src1 | csr_rdata) : src1; // csrrs : csrrw

	assign wb_we   = ex_valid && (opcode == OPC_LUI || opcode == OPC_AUIPC || is_jal ||
		is_jalr || is_alu || is_csr);
	assign wb_rd   = rd;
	assign wb_data = is_csr ? csr_rdata : alu_res; // old csr value to rd

	a_store_mask: assert final (!store_valid || store_wmask inside {4'h1, 4'h3, 4'hf});

	// relies on an aligned pc and the decoder's even b/j immediates
	a_jump_align: assert final (!(jump_valid && !is_jalr) || !jump_target[0]);

endmodule

`default_nettype wire

// File: design/rvx_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module rvx_exec_top import rvx_pkg::*; #(
	parameter int NREGS = 32
) (
	input  logic            clock,
	input  logic            arst_n,
	input  logic            inst_valid,
	input  logic [31:0]     inst,
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] csr_rdata,
	output logic            wb_we,
	output logic [4:0]      wb_rd,
	output logic [XLEN-1:0] wb_data,
	output logic            jump_valid,
	output logic [XLEN-1:0] jump_target,
	output logic            store_valid,
	output logic [XLEN-1:0] store_addr,
	output logic [XLEN-1:0] store_data,
	output logic [3:0]      store_wmask,
	output logic            csr_we,
	output logic [XLEN-1:0] csr_wdata
);

	inst_fmt_e       id_fmt, ex_fmt;
	logic [6:0]      id_opcode, id_funct7, ex_opcode, ex_funct7;
	logic [2:0]      id_funct3, ex_funct3;
	logic [4:0]      id_rd, id_rs1, id_rs2, ex_rd;
	logic [XLEN-1:0] id_imm, ex_imm, ex_pc;
	logic [XLEN-1:0] rdata1, rdata2, src1, src2;
	logic            ex_valid;

	rvx_idu u_idu (
		.inst_valid(inst_valid), .inst(inst), .fmt(id_fmt), .opcode(id_opcode),
		.funct3(id_funct3), .funct7(id_funct7), .rd(id_rd), .rs1(id_rs1), .rs2(id_rs2),
		.imm(id_imm)
	);

	rvx_gpr #(.NREGS(NREGS)) u_gpr (
		.clock(clock), .arst_n(arst_n), .raddr1(id_rs1), .raddr2(id_rs2),
		.rdata1(rdata1), .rdata2(rdata2), .we(wb_we), .waddr(wb_rd), .wdata(wb_data)
	);

	rvx_id_ex_buf #(.NREGS(NREGS)) u_buf (
		.clock(clock), .arst_n(arst_n), .inst_valid(inst_valid), .fmt(id_fmt),
		.opcode(id_opcode), .funct3(id_funct3), .funct7(id_funct7), .rd(id_rd),
		.rs1(id_rs1), .rs2(id_rs2), .imm(id_imm), .rdata1(rdata1), .rdata2(rdata2),
		.pc(pc), .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
		.ex_valid(ex_valid), .ex_fmt(ex_fmt), .ex_opcode(ex_opcode),
		.ex_funct3(ex_funct3), .ex_funct7(ex_funct7), .ex_rd(ex_rd), .ex_imm(ex_imm),
		.ex_pc(ex_pc), .src1(src1), .src2(src2)
	);

	rvx_exu u_exu (
		.ex_valid(ex_valid), .fmt(ex_fmt), .opcode(ex_opcode), .funct3(ex_funct3),
		.funct7(ex_funct7), .rd(ex_rd), .src1(src1), .src2(src2), .imm(ex_imm),
		.pc(ex_pc), .csr_rdata(csr_rdata),
		.wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
		.jump_valid(jump_valid), .jump_target(jump_target),
		.store_valid(store_valid), .store_addr(store_addr), .store_data(store_data),
		.store_wmask(store_wmask), .csr_we(csr_we), .csr_wdata(csr_wdata)
	);

endmodule

`default_nettype wire

// File: tb/rvx_exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rvx_exec_tb import rvx_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int MAX_INSTS  = 300; // instruction budget over all sections
	localparam int N_ALU      = 100;
	localparam int N_MIX      = 60;
	localparam logic [31:0] SEED = 32'h57e8cbe6;
	localparam logic [2:0] BR_KINDS [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	localparam logic [4:0] PAIR_A [7] = '{5'd1, 5'd2, 5'd1, 5'd3, 5'd0, 5'd3, 5'd4};
	localparam logic [4:0] PAIR_B [7] = '{5'd2, 5'd1, 5'd1, 5'd0, 5'd3, 5'd4, 5'd3};

	typedef struct packed {
		logic        wb_we;
		logic [4:0]  wb_rd;
		logic [31:0] wb_data;
		logic        jump_valid;
		logic [31:0] jump_target;
		logic        store_valid;
		logic [31:0] store_addr;
		logic [31:0] store_data;
		logic [3:0]  store_wmask;
		logic        csr_we;
		logic [31:0] csr_wdata;
		logic [31:0] csr_rdata;
	} expect_t;

	logic        clock;
	logic        arst_n;
	logic        inst_valid;
	logic [31:0] inst;
	logic [31:0] pc;
	logic [31:0] csr_rdata;
	logic        wb_we;
	logic [4:0]  wb_rd;
	logic [31:0] wb_data;
	logic        jump_valid;
	logic [31:0] jump_target;
	logic        store_valid;
	logic [31:0] store_addr;
	logic [31:0] store_data;
	logic [3:0]  store_wmask;
	logic        csr_we;
	logic [31:0] csr_wdata;

	logic [31:0] shadow [32]; // architectural register state, in program order
	expect_t     exp_q [$];
	string       name_q [$];
	expect_t     cur = '0;
	expect_t     nxt;
	string       cur_name = "reset";
	string       test_name = "reset";
	int          errors = 0;
	int          n_insts = 0;

	rvx_exec_top #(.NREGS(32)) UUT (.*);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#((MAX_INSTS + 20) * CLK_PERIOD * 2);
		$display("Timeout: the run did not finish before the watchdog limit");
		$display("Test FAILED");
		$finish;
	end

	function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic sub,
			input logic arith, input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return sub ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: begin
				if (arith)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			3'b111: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	task automatic report_mismatch(input string sig, input logic [31:0] expected,
			input logic [31:0] actual);
		errors++;
		$display("Error %s %s: expected %h, actual %h", cur_name, sig, expected, actual);
	endtask

	// encode, model in program order, then strobe on this edge
	task automatic issue(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
			input logic [31:0] raw_imm);
		expect_t     e;
		logic [31:0] a, b, immv, word, pc_val;
		e = '0;
		pc_val = $urandom & 32'hffff_fffc;
		e.csr_rdata = $urandom;
		a = shadow[rs1];
		b = shadow[rs2];
		case (opc)
			OPC_LUI, OPC_AUIPC: immv = {raw_imm[31:12], 12'b0};
			OPC_JAL:            immv = {{11{raw_imm[20]}}, raw_imm[20:1], 1'b0};
			OPC_BRANCH:         immv = {{19{raw_imm[12]}}, raw_imm[12:1], 1'b0};
			default:            immv = {{20{raw_imm[11]}}, raw_imm[11:0]};
		endcase
		case (opc)
			OPC_OP:             word = {f7, rs2, rs1, f3, rd, opc};
			OPC_STORE:          word = {immv[11:5], rs2, rs1, f3, immv[4:0], opc};
			OPC_BRANCH: word = {immv[12], immv[10:5], rs2, rs1, f3, immv[4:1], immv[11], opc};
			OPC_LUI, OPC_AUIPC: word = {immv[31:12], rd, opc};
			OPC_JAL: word = {immv[20], immv[10:1], immv[11], immv[19:12], rd, opc};
			default:            word = {immv[11:0], rs1, f3, rd, opc};
		endcase
		e.wb_rd = rd;
		case (opc)
			OPC_OP:    e.wb_data = alu_result(f3, f7[5], f7[5], a, b);
			OPC_OPIMM: e.wb_data = alu_result(f3, 1'b0, immv[10], a, immv);
			OPC_LUI:   e.wb_data = immv;
			OPC_AUIPC: e.wb_data = pc_val + immv;
			OPC_SYSTEM: begin
				e.csr_we    = 1'b1;
				e.csr_wdata = (f3 == 3'b010) ? (a | e.csr_rdata) : a; // csrrs sets bits
				e.wb_data   = e.csr_rdata; // old csr value
			end
			default:   e.wb_data = pc_val + 32'd4; // link
		endcase
		e.wb_we = !(opc inside {OPC_BRANCH, OPC_STORE});
		e.jump_valid  = (opc inside {OPC_JAL, OPC_JALR}) ||
			(opc == OPC_BRANCH && branch_taken(f3, a, b));
		e.jump_target = (opc == OPC_JALR) ? ((a + immv) & ~32'd1) : pc_val + immv;
		if (opc == OPC_STORE) begin
			e.store_valid = 1'b1;
			e.store_addr  = a + immv;
			e.store_data  = b;
			e.store_wmask = (f3 == 3'd0) ? 4'h1 : (f3 == 3'd1) ? 4'h3 : 4'hf;
		end
		if (e.wb_we && rd != 5'd0)
			shadow[rd] = e.wb_data;
		@(posedge clock);
		exp_q.push_back(e);
		name_q.push_back(test_name);
		inst       <= word;
		pc         <= pc_val;
		inst_valid <= 1'b1;
		n_insts++;
	endtask

	task automatic idle();
		@(posedge clock);
		inst_valid <= 1'b0;
	endtask

	// kind: 0 alu, 1 upper or jump, 2 branch, 3 store, 4 csr
	task automatic random_inst(input int kind);
		logic [2:0]  f3;
		logic [4:0]  rd, rs1, rs2;
		logic [31:0] imm;
		logic        alt;
		f3  = 3'($urandom);
		rd  = 5'($urandom);
		rs1 = 5'($urandom);
		rs2 = 5'($urandom);
		imm = $urandom;
		alt = 1'($urandom);
		case (kind)
			0: begin
				if (alt) begin
					issue(OPC_OP, f3, ((f3 == 3'd0 || f3 == 3'd5) && imm[0]) ? 7'h20 : 7'h00,
						rd, rs1, rs2, '0);
				end else begin
					if (f3 == 3'd1 || f3 == 3'd5)
						imm[11:5] = (f3 == 3'd5 && imm[0]) ? 7'h20 : 7'h00; // shamt form
					issue(OPC_OPIMM, f3, 7'h00, rd, rs1, rs2, imm);
				end
			end
			1: begin
				case (f3[1:0])
					2'd0:    issue(OPC_LUI, 3'd0, 7'd0, rd, 5'd0, 5'd0, imm);
					2'd1:    issue(OPC_AUIPC, 3'd0, 7'd0, rd, 5'd0, 5'd0, imm);
					2'd2:    issue(OPC_JAL, 3'd0, 7'd0, rd, 5'd0, 5'd0, imm);
					default: issue(OPC_JALR, 3'd0, 7'd0, rd, rs1, 5'd0, imm);
				endcase
			end
			2: issue(OPC_BRANCH, f3[2] ? f3 : {2'b00, f3[0]}, 7'd0, 5'd0, rs1, rs2, imm);
			3: issue(OPC_STORE, 3'($urandom_range(2)), 7'd0, 5'd0, rs1, rs2, imm);
			default: issue(OPC_SYSTEM, alt ? 3'b010 : 3'b001, 7'd0, rd, rs1, 5'd0, imm);
		endcase
	endtask

	always @(posedge clock) begin
		if (inst_valid) begin
			nxt = exp_q.pop_front();
			cur       <= nxt;
			cur_name  <= name_q.pop_front();
			csr_rdata <= nxt.csr_rdata;
		end else begin
			cur <= '0;
		end
	end

	a_wb_we: assert property (@(negedge clock) wb_we == cur.wb_we)
		else report_mismatch("wb_we", cur.wb_we, wb_we);
	a_wb_rd: assert property (@(negedge clock) cur.wb_we |-> wb_rd == cur.wb_rd)
		else report_mismatch("wb_rd", cur.wb_rd, wb_rd);
	a_wb_data: assert property (@(negedge clock) cur.wb_we |-> wb_data == cur.wb_data)
		else report_mismatch("wb_data", cur.wb_data, wb_data);
	a_jump_valid: assert property (@(negedge clock) jump_valid == cur.jump_valid)
		else report_mismatch("jump_valid", cur.jump_valid, jump_valid);
	a_jump_target: assert property (@(negedge clock)
		cur.jump_valid |-> jump_target == cur.jump_target)
		else report_mismatch("jump_target", cur.jump_target, jump_target);
	a_store_valid: assert property (@(negedge clock) store_valid == cur.store_valid)
		else report_mismatch("store_valid", cur.store_valid, store_valid);
	a_store_addr: assert property (@(negedge clock)
		cur.store_valid |-> store_addr == cur.store_addr)
		else report_mismatch("store_addr", cur.store_addr, store_addr);
	a_store_data: assert property (@(negedge clock)
		cur.store_valid |-> store_data == cur.store_data)
		else report_mismatch("store_data", cur.store_data, store_data);
	a_store_wmask: assert property (@(negedge clock)
		cur.store_valid |-> store_wmask == cur.store_wmask)
		else report_mismatch("store_wmask", cur.store_wmask, store_wmask);
	a_csr_we: assert property (@(negedge clock) csr_we == cur.csr_we)
		else report_mismatch("csr_we", cur.csr_we, csr_we);
	a_csr_wdata: assert property (@(negedge clock) cur.csr_we |-> csr_wdata == cur.csr_wdata)
		else report_mismatch("csr_wdata", cur.csr_wdata, csr_wdata);

	initial begin
		int r;
		int k;
		void'($urandom(SEED));
		foreach (shadow[i])
			shadow[i] = '0;
		arst_n     = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		pc         = '0;
		csr_rdata  = '0;
		repeat (5) @(posedge clock);
		arst_n <= 1'b1;
		repeat (2) @(posedge clock); // outputs must stay idle after reset

		test_name = "lui_fill";
		for (r = 1; r < 32; r++)
			issue(OPC_LUI, 3'd0, 7'd0, 5'(r), 5'd0, 5'd0, $urandom);
		test_name = "alu_random";
		repeat (N_ALU) random_inst(0);
		test_name = "upper_jump";
		repeat (12) random_inst(1);

		test_name = "branch";
		issue(OPC_LUI, 3'd0, 7'd0, 5'd1, 5'd0, 5'd0, 32'h8000_0000); // most negative
		issue(OPC_OPIMM, 3'd0, 7'd0, 5'd2, 5'd1, 5'd0, 32'hfff); // wraps to most positive
		issue(OPC_OPIMM, 3'd0, 7'd0, 5'd3, 5'd0, 5'd0, 32'hfff);
		issue(OPC_OPIMM, 3'd0, 7'd0, 5'd4, 5'd0, 5'd0, 32'd1);
		for (r = 0; r < 7; r++)
			for (k = 0; k < 6; k++)
				issue(OPC_BRANCH, BR_KINDS[k], 7'd0, 5'd0, PAIR_A[r], PAIR_B[r], $urandom);

		test_name = "store";
		repeat (9) random_inst(3);
		test_name = "csr";
		repeat (8) random_inst(4);

		test_name = "forward_x0";
		issue(OPC_OPIMM, 3'd0, 7'd0, 5'd7, 5'd0, 5'd0, 32'h123);
		issue(OPC_OPIMM, 3'd0, 7'd0, 5'd7, 5'd7, 5'd0, 32'd1);
		issue(OPC_OPIMM, 3'd0, 7'd0, 5'd7, 5'd7, 5'd0, 32'd1);
		issue(OPC_OP, 3'd0, 7'd0, 5'd8, 5'd7, 5'd7, '0); // both sources forwarded
		issue(OPC_OPIMM, 3'd0, 7'd0, 5'd0, 5'd8, 5'd0, 32'h55);
		issue(OPC_OP, 3'd0, 7'd0, 5'd9, 5'd0, 5'd0, '0);
		issue(OPC_OP, 3'd0, 7'd0, 5'd9, 5'd0, 5'd8, '0);

		test_name = "mixed";
		repeat (N_MIX) random_inst($urandom_range(4));

		idle();
		repeat (3) @(posedge clock);
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d expected results were never checked", exp_q.size());
		end
		$display("instructions %0d, errors %0d", n_insts, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
design/rvx_pkg.sv
design/rvx_idu.sv
design/rvx_gpr.sv
design/rvx_id_ex_buf.sv
design/rvx_exu.sv
design/rvx_exec_top.sv
tb/rvx_exec_tb.sv

// File: Bender.yml
package:
  name: rvx_exec

sources:
  - files:
      - design/rvx_pkg.sv
      - design/rvx_idu.sv
      - design/rvx_gpr.sv
      - design/rvx_id_ex_buf.sv
      - design/rvx_exu.sv
      - design/rvx_exec_top.sv
  - target: simulation
    files:
      - tb/rvx_exec_tb.sv
